/* dv/rs_cluster_checker.sv */
////////////////////
// Scoreboard for the issue cluster. Keeps each dispatched instruction
// by dest tag, wakes its operands from both buses like the hardware
// and compares every result against the opcode rule
////////////////////

`timescale 1ns/1ps

module rs_cluster_checker (
	input logic                      clock,
	input logic                      reset,
	input logic                      dispatch_valid,
	input logic [rs_pkg::FUNC_W-1:0] dispatch_func,
	input logic [rs_pkg::TAG_W-1:0]  dispatch_dest,
	input logic [rs_pkg::DATA_W-1:0] dispatch_a_value,
	input logic [rs_pkg::TAG_W-1:0]  dispatch_a_tag,
	input logic                      dispatch_a_ready,
	input logic [rs_pkg::DATA_W-1:0] dispatch_b_value,
	input logic [rs_pkg::TAG_W-1:0]  dispatch_b_tag,
	input logic                      dispatch_b_ready,
	input logic                      flush,
	input logic                      rs_full,
	input logic                      ext_cdb_valid,
	input logic [rs_pkg::TAG_W-1:0]  ext_cdb_tag,
	input logic [rs_pkg::DATA_W-1:0] ext_cdb_value,
	input logic                      result_valid,
	input logic [rs_pkg::TAG_W-1:0]  result_tag,
	input logic [rs_pkg::DATA_W-1:0] result_value
);
	import rs_pkg::*;

	int                  error_count   = 0;
	int                  cycle         = 0;
	string               test_name     = "reset";        // Set by the testbench
	logic                fixed_latency = 1'b0;           // Empty cluster, expect 3 edges
	logic [2**TAG_W-1:0] pend_valid    = '0;             // Tag awaiting its result
	logic [FUNC_W-1:0]   pend_func [2**TAG_W];
	logic [DATA_W:0]     pend_a    [2**TAG_W];           // {ready, value or tag}
	logic [DATA_W:0]     pend_b    [2**TAG_W];
	int                  pend_cycle [2**TAG_W];

	// Reference ALU rule by raw function code
	function automatic logic [DATA_W-1:0] alu_rule(
		input logic [FUNC_W-1:0] f,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		case (f)
			3'd0:    return a + b;
			3'd1:    return a - b;
			3'd2:    return a & b;
			3'd3:    return a | b;
			3'd4:    return a ^ b;
			3'd5:    return a << b[4:0];
			3'd6:    return a >> b[4:0];
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	// Pending operand picks up this cycle's broadcast, external bus first
	function automatic logic [DATA_W:0] snoop(input logic [DATA_W:0] src);
		if (src[DATA_W])
			return src;
		if (ext_cdb_valid && ext_cdb_tag == src[TAG_W-1:0])
			return {1'b1, ext_cdb_value};
		if (result_valid && result_tag == src[TAG_W-1:0])
			return {1'b1, result_value};
		return src;
	endfunction

	task automatic check_result();
		logic [DATA_W-1:0] expected;
		if (!pend_valid[result_tag])
		begin
			$display("Unexpected result for tag %0d during %s", result_tag, test_name);
			error_count++;
		end
		else if (!pend_a[result_tag][DATA_W] || !pend_b[result_tag][DATA_W])
		begin
			$display("Tag %0d produced a result before its operands arrived in %s",
				result_tag, test_name);
			error_count++;
		end
		else
		begin
			expected = alu_rule(pend_func[result_tag], pend_a[result_tag][DATA_W-1:0],
				pend_b[result_tag][DATA_W-1:0]);
			if (expected !== result_value)
			begin
				$display("ERROR %s: tag %0d expected %h actual %h", test_name, result_tag,
					expected, result_value);
				error_count++;
			end
			if (fixed_latency && cycle - pend_cycle[result_tag] != 3)
			begin
				$display("ERROR %s: latency of tag %0d expected 3 actual %0d", test_name,
					result_tag, cycle - pend_cycle[result_tag]);
				error_count++;
			end
		end
		pend_valid[result_tag] = 1'b0;                   // Exactly one result per tag
	endtask

	always @(posedge clock)
	begin
		if (reset)
			pend_valid = '0;
		else
		begin
			cycle++;
			if (result_valid)
				check_result();
			for (int t = 0; t < 2**TAG_W; t++)
			begin
				// Still waiting at flush means still in an entry, so dropped
				if (flush && pend_valid[t] && !(pend_a[t][DATA_W] && pend_b[t][DATA_W]))
					pend_valid[t] = 1'b0;
				if (pend_valid[t])
				begin
					pend_a[t] = snoop(pend_a[t]);
					pend_b[t] = snoop(pend_b[t]);
				end
			end
			if (dispatch_valid && !rs_full && !flush)    // Accepted dispatch
			begin
				pend_valid[dispatch_dest] = 1'b1;
				pend_func[dispatch_dest]  = dispatch_func;
				pend_cycle[dispatch_dest] = cycle;
				pend_a[dispatch_dest] = snoop(dispatch_a_ready ? {1'b1, dispatch_a_value} :
					{1'b0, {(DATA_W-TAG_W){1'b0}}, dispatch_a_tag});
				pend_b[dispatch_dest] = snoop(dispatch_b_ready ? {1'b1, dispatch_b_value} :
					{1'b0, {(DATA_W-TAG_W){1'b0}}, dispatch_b_tag});
			end
		end
	end

endmodule

/* dv/rs_cluster_properties.sv */
////////////////////
// Concurrent assertions on the issue cluster, bound to the top level
////////////////////

`timescale 1ns/1ps

module rs_cluster_properties (
	input logic                          clock,
	input logic                          reset,
	input logic                          result_valid,
	input logic                          rs_full,
	input logic [rs_pkg::RS_ENTRIES-1:0] load,          // Decode one-hot entry write
	input logic [rs_pkg::RS_ENTRIES-1:0] issue_free     // Selector free strobes
);

	a_result_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(result_valid))
		else $error("result_valid is unknown after reset");

	a_full_no_load: assert property (@(posedge clock) disable iff (reset)
		rs_full |-> (load == '0))
		else $error("entry loaded while rs_full is high");

	a_free_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(issue_free))
		else $error("more than one entry freed for issue in one cycle");

endmodule

bind rs_cluster_top rs_cluster_properties props_i (
	.clock        (clock),
	.reset        (reset),
	.result_valid (result_valid),
	.rs_full      (rs_full),
	.load         (disp.load),
	.issue_free   (issue_free)
);

/* dv/rs_cluster_tb.sv */
////////////////////
// Testbench for the issue cluster. Random dispatches from an LCG,
// external bus broadcasts from a queue, flush test and final report
////////////////////

`timescale 1ns/1ps

module rs_cluster_tb;
	import rs_pkg::*;

	logic                clock = 1'b0;
	logic                reset;
	logic                dispatch_valid, dispatch_a_ready, dispatch_b_ready;
	logic [FUNC_W-1:0]   dispatch_func;
	logic [TAG_W-1:0]    dispatch_dest, dispatch_a_tag, dispatch_b_tag;
	logic [DATA_W-1:0]   dispatch_a_value, dispatch_b_value;
	logic                flush, ext_cdb_valid;
	logic [TAG_W-1:0]    ext_cdb_tag;
	logic [DATA_W-1:0]   ext_cdb_value;
	logic                rs_full, result_valid;
	logic [TAG_W-1:0]    result_tag;
	logic [DATA_W-1:0]   result_value;

	logic                stage_valid = 1'b0;             // Dispatch for next cycle
	logic                stage_flush = 1'b0;
	logic [FUNC_W-1:0]   stage_func;
	logic [TAG_W-1:0]    stage_dest;
	logic [DATA_W:0]     stage_a, stage_b;               // {ready, value or tag}
	logic [TAG_W-1:0]    ext_tag_q [$];                  // Scheduled CDB2 broadcasts
	logic [DATA_W-1:0]   ext_value_q [$];
	int                  ext_due_q [$];
	int                  due_idx;
	int                  tb_cycle  = 0;
	int                  tb_errors = 0;
	logic [31:0]         lcg_state = 32'hd8b;
	logic [TAG_W-1:0]    next_tag  = '0;                 // Round robin dest pointer
	logic [DATA_W:0]     src_a, src_b;
	logic [TAG_W-1:0]    dest;
	logic [TAG_W-1:0]    flushed_tag [RS_ENTRIES];       // Dests of the flushed waiters

	rs_cluster_top dut_i (.*);
	rs_cluster_checker checker_i (.*);

	always #5 clock = ~clock;

	////////////////////
	// Input driver, staged at negedge
	////////////////////
	always @(posedge clock)
	begin
		tb_cycle = tb_cycle + 1;
		dispatch_valid <= stage_valid;
		if (stage_valid)
		begin
			dispatch_func    <= stage_func;
			dispatch_dest    <= stage_dest;
			dispatch_a_ready <= stage_a[DATA_W];
			dispatch_a_value <= stage_a[DATA_W-1:0];
			dispatch_a_tag   <= stage_a[TAG_W-1:0];
			dispatch_b_ready <= stage_b[DATA_W];
			dispatch_b_value <= stage_b[DATA_W-1:0];
			dispatch_b_tag   <= stage_b[TAG_W-1:0];
		end
		flush <= stage_flush;
		stage_valid = 1'b0;
		stage_flush = 1'b0;
		ext_cdb_valid <= 1'b0;
		due_idx = -1;
		for (int i = ext_due_q.size() - 1; i >= 0; i--) // Oldest due entry
			if (ext_due_q[i] <= tb_cycle)
				due_idx = i;
		if (due_idx >= 0)
		begin
			ext_cdb_valid <= 1'b1;
			ext_cdb_tag   <= ext_tag_q[due_idx];
			ext_cdb_value <= ext_value_q[due_idx];
			ext_tag_q.delete(due_idx);
			ext_value_q.delete(due_idx);
			ext_due_q.delete(due_idx);
		end
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function int rand_below(input int n);
		return int'(lcg_next() >> 12) % n;
	endfunction

	// Tag still owed a result or an external broadcast
	function logic tag_busy(input logic [TAG_W-1:0] t);
		if (checker_i.pend_valid[t])
			return 1'b1;
		foreach (ext_tag_q[i])
			if (ext_tag_q[i] == t)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic alloc_tag(output logic [TAG_W-1:0] t);
		for (int i = 0; i < 2**TAG_W; i++)
		begin
			next_tag = next_tag + 1'b1;
			if (!tag_busy(next_tag))
				break;
		end
		t = next_tag;
	endtask

	// Form 0 ready value, 1 unfinished producer, 2 external tag
	task automatic pick_source(input int form, output logic [DATA_W:0] src);
		logic [TAG_W-1:0] t;
		logic [TAG_W-1:0] cand [$];
		src = {1'b1, lcg_next()};
		if (form == 1)
		begin
			for (int i = 0; i < 2**TAG_W; i++)           // Not broadcasting this cycle
				if (checker_i.pend_valid[i] && !(result_valid && result_tag == TAG_W'(i)))
					cand.push_back(TAG_W'(i));
			if (cand.size() > 0)
				src = {1'b0, {(DATA_W-TAG_W){1'b0}}, cand[rand_below(cand.size())]};
		end
		else if (form == 2)
		begin
			alloc_tag(t);
			ext_tag_q.push_back(t);
			ext_value_q.push_back(lcg_next());
			ext_due_q.push_back(tb_cycle + 1 + rand_below(4)); // Delay 0 is the bypass
			src = {1'b0, {(DATA_W-TAG_W){1'b0}}, t};
		end
	endtask

	task automatic stage_instr(input int f, input logic [TAG_W-1:0] d,
		input logic [DATA_W:0] a, input logic [DATA_W:0] b);
		stage_func  = FUNC_W'(f);
		stage_dest  = d;
		stage_a     = a;
		stage_b     = b;
		stage_valid = 1'b1;
	endtask

	task automatic dispatch_gap(input int extra);
		int n = 0;
		repeat (2 + extra) @(negedge clock);
		while (rs_full && n < 300)
		begin
			@(negedge clock);
			n++;
		end
		if (rs_full)
		begin
			$display("Timeout: reservation station stayed full");
			tb_errors++;
		end
	endtask

	task automatic wait_idle(input string what);
		int n = 0;
		while ((checker_i.pend_valid != '0 || ext_due_q.size() != 0) && n < 300)
		begin
			@(negedge clock);
			n++;
		end
		if (n >= 300)
		begin
			$display("Timeout: results still outstanding after %s", what);
			tb_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %0b actual %0b", name, expected, actual);
			tb_errors++;
		end
	endtask

	task automatic random_run(input string name, input int count, input logic ext_only);
		checker_i.test_name = name;
		for (int i = 0; i < count; i++)
		begin
			pick_source(ext_only ? 2 : rand_below(3), src_a);
			pick_source(ext_only ? 2 * rand_below(2) : rand_below(3), src_b);
			alloc_tag(dest);
			stage_instr(rand_below(8), dest, src_a, src_b);
			dispatch_gap(rand_below(3));
		end
		wait_idle(name);
	endtask

	initial
	begin
		reset            = 1'b1;
		dispatch_valid   = 1'b0;
		dispatch_func    = '0;
		dispatch_dest    = '0;
		dispatch_a_value = '0;
		dispatch_a_tag   = '0;
		dispatch_a_ready = 1'b0;
		dispatch_b_value = '0;
		dispatch_b_tag   = '0;
		dispatch_b_ready = 1'b0;
		flush            = 1'b0;
		ext_cdb_valid    = 1'b0;
		ext_cdb_tag      = '0;
		ext_cdb_value    = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_bit("reset result_valid", 1'b0, result_valid);
		check_bit("reset rs_full", 1'b0, rs_full);

		////////////////////
		// Opcodes, ready operands, empty cluster
		////////////////////
		checker_i.test_name     = "opcodes";
		checker_i.fixed_latency = 1'b1;
		for (int f = 0; f < 8; f++)
		begin
			pick_source(0, src_a);
			pick_source(0, src_b);
			alloc_tag(dest);
			stage_instr(f, dest, src_a, src_b);
			dispatch_gap(0);
			wait_idle("opcodes");
		end
		checker_i.fixed_latency = 1'b0;

		random_run("ext_wakeup", 16, 1'b1);
		random_run("chains", 80, 1'b0);

		////////////////////
		// Fill with waiters, then flush
		////////////////////
		checker_i.test_name = "flush";
		for (int i = 0; i < RS_ENTRIES; i++)
		begin
			alloc_tag(dest);                             // Waits on its own tag
			flushed_tag[i] = dest;
			src_a = {1'b0, {(DATA_W-TAG_W){1'b0}}, dest};
			stage_instr(rand_below(8), dest, src_a, src_a);
			repeat (2) @(negedge clock);
		end
		check_bit("flush rs_full before", 1'b1, rs_full);
		stage_flush = 1'b1;
		repeat (2) @(negedge clock);
		check_bit("flush rs_full after", 1'b0, rs_full);
		foreach (flushed_tag[i])                         // Wakes any entry still held
		begin
			ext_tag_q.push_back(flushed_tag[i]);
			ext_value_q.push_back(lcg_next());
			ext_due_q.push_back(tb_cycle);
		end
		wait_idle("flush");
		repeat (6) @(negedge clock);                    // Any flushed result shows up here

		random_run("after_flush", 20, 1'b0);

		$display("Run finished: %0d testbench errors, %0d checker errors",
			tb_errors, checker_i.error_count);
		if (tb_errors == 0 && checker_i.error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* run_verilator.sh */
#!/bin/sh
# Build and run the issue cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rs_cluster_tb \
	-f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vrs_cluster_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* tb.f */
verilog/rs_pkg.sv
verilog/rs_if.sv
verilog/dispatch_decode.sv
verilog/rs_entry.sv
verilog/issue_select.sv
verilog/alu_execute.sv
verilog/rs_cluster_top.sv
dv/rs_cluster_properties.sv
dv/rs_cluster_checker.sv
dv/rs_cluster_tb.sv

/* verilog/alu_execute.sv */
////////////////////
// Single ALU with its result register. The registered output is the
// result stage and drives CDB1
////////////////////

`timescale 1ns/1ps

module alu_execute (
	input  logic                      clock,
	input  logic                      reset,
	issue_if.execute                  iss,
	output logic                      result_valid,
	output logic [rs_pkg::TAG_W-1:0]  result_tag,
	output logic [rs_pkg::DATA_W-1:0] result_value
);
	import rs_pkg::*;

	logic [DATA_W-1:0]  alu_out;
	logic [SHAMT_W-1:0] shamt;

	assign shamt = iss.b[SHAMT_W-1:0];                   // Low 5 bits of b

	always_comb
	begin
		case (iss.op)
			ALU_ADD: alu_out = iss.a + iss.b;
			ALU_SUB: alu_out = iss.a - iss.b;
			ALU_AND: alu_out = iss.a & iss.b;
			ALU_OR:  alu_out = iss.a | iss.b;
			ALU_XOR: alu_out = iss.a ^ iss.b;
			ALU_SLL: alu_out = iss.a << shamt;
			ALU_SRL: alu_out = iss.a >> shamt;           // Logical
			ALU_SLT: alu_out = {{(DATA_W-1){1'b0}}, $signed(iss.a) < $signed(iss.b)};
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= iss.valid;
	end

	// Broadcast payload, held between results
	always_ff @(posedge clock)
	begin
		if (iss.valid)
		begin
			result_tag   <= iss.dest;
			result_value <= alu_out;
		end
	end

endmodule

/* verilog/dispatch_decode.sv */
////////////////////
// Dispatch front end. Decodes the function code, bypasses any
// source tag seen on a CDB this cycle and writes the lowest free entry
////////////////////

`timescale 1ns/1ps

module dispatch_decode (
	input  logic                          dispatch_valid,    // Single-cycle strobe
	input  logic [rs_pkg::FUNC_W-1:0]     dispatch_func,
	input  logic [rs_pkg::TAG_W-1:0]      dispatch_dest,
	input  logic [rs_pkg::DATA_W-1:0]     dispatch_a_value,
	input  logic [rs_pkg::TAG_W-1:0]      dispatch_a_tag,
	input  logic                          dispatch_a_ready,
	input  logic [rs_pkg::DATA_W-1:0]     dispatch_b_value,
	input  logic [rs_pkg::TAG_W-1:0]      dispatch_b_tag,
	input  logic                          dispatch_b_ready,
	input  logic                          flush,
	input  logic                          cdb1_valid,        // Own ALU result
	input  logic [rs_pkg::TAG_W-1:0]      cdb1_tag,
	input  logic [rs_pkg::DATA_W-1:0]     cdb1_value,
	input  logic                          cdb2_valid,        // External bus
	input  logic [rs_pkg::TAG_W-1:0]      cdb2_tag,
	input  logic [rs_pkg::DATA_W-1:0]     cdb2_value,
	input  logic [rs_pkg::RS_ENTRIES-1:0] entry_free,
	output logic                          rs_full,
	dispatch_if.decode                    disp
);
	import rs_pkg::*;

	logic [DATA_W:0]   src_a;                            // {ready, value or tag}
	logic [DATA_W:0]   src_b;
	logic [IDX_W-1:0]  alloc_idx;
	logic              alloc_found;

	// Pending source picks up a value broadcast this same cycle, CDB2 first
	function automatic logic [DATA_W:0] resolve_src(
		input logic              ready,
		input logic [DATA_W-1:0] value,
		input logic [TAG_W-1:0]  tag
	);
		logic [DATA_W:0] res;
		if (ready)
			res = {1'b1, value};
		else if (cdb2_valid && cdb2_tag == tag)
			res = {1'b1, cdb2_value};
		else if (cdb1_valid && cdb1_tag == tag)
			res = {1'b1, cdb1_value};
		else
			res = {1'b0, {(DATA_W-TAG_W){1'b0}}, tag};       // Park tag in value field
		return res;
	endfunction

	assign src_a = resolve_src(dispatch_a_ready, dispatch_a_value, dispatch_a_tag);
	assign src_b = resolve_src(dispatch_b_ready, dispatch_b_value, dispatch_b_tag);

	assign disp.a_ready = src_a[DATA_W];
	assign disp.a       = src_a[DATA_W-1:0];
	assign disp.b_ready = src_b[DATA_W];
	assign disp.b       = src_b[DATA_W-1:0];
	assign disp.dest    = dispatch_dest;
	assign rs_full      = ~|entry_free;                  // Status only, no stall

	always_comb
	begin
		case (dispatch_func)
			3'd0:    disp.op = ALU_ADD;
			3'd1:    disp.op = ALU_SUB;
			3'd2:    disp.op = ALU_AND;
			3'd3:    disp.op = ALU_OR;
			3'd4:    disp.op = ALU_XOR;
			3'd5:    disp.op = ALU_SLL;
			3'd6:    disp.op = ALU_SRL;
			default: disp.op = ALU_SLT;
		endcase
	end

	// Lowest-indexed free entry wins
	always_comb
	begin
		alloc_found = 1'b0;
		alloc_idx   = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--)
		begin
			if (entry_free[i])
			begin
				alloc_found = 1'b1;
				alloc_idx   = IDX_W'(i);
			end
		end
		disp.load = '0;
		if (dispatch_valid && alloc_found && !flush)      // Dropped when full or flushing
			disp.load[alloc_idx] = 1'b1;
	end

endmodule

/* verilog/issue_select.sv */
////////////////////
// Fixed-priority issue. Lowest ready entry is freed and its fields
// registered onto the issue bus, one instruction per cycle
////////////////////

`timescale 1ns/1ps

module issue_select (
	input  logic                          clock,
	input  logic                          reset,
	input  rs_pkg::entry_state_e          entry_state [rs_pkg::RS_ENTRIES],
	input  rs_pkg::alu_op_e               entry_op    [rs_pkg::RS_ENTRIES],
	input  logic [rs_pkg::DATA_W-1:0]     entry_a     [rs_pkg::RS_ENTRIES],
	input  logic [rs_pkg::DATA_W-1:0]     entry_b     [rs_pkg::RS_ENTRIES],
	input  logic [rs_pkg::TAG_W-1:0]      entry_dest  [rs_pkg::RS_ENTRIES],
	output logic [rs_pkg::RS_ENTRIES-1:0] issue_free,        // One-hot free of winner
	issue_if.select                       iss
);
	import rs_pkg::*;

	logic [IDX_W-1:0] winner;
	logic             found;

	always_comb
	begin
		found      = 1'b0;
		winner     = '0;
		issue_free = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--)        // Last hit is lowest index
		begin
			if (entry_state[i] == ENTRY_READY)
			begin
				found  = 1'b1;
				winner = IDX_W'(i);
			end
		end
		if (found)
			issue_free[winner] = 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			iss.valid <= 1'b0;
		else
			iss.valid <= found;                          // Strobe, never held
	end

	// Issue payload
	always_ff @(posedge clock)
	begin
		if (found)
		begin
			iss.op   <= entry_op[winner];
			iss.a    <= entry_a[winner];
			iss.b    <= entry_b[winner];
			iss.dest <= entry_dest[winner];
		end
	end

endmodule

/* verilog/rs_cluster_top.sv */
////////////////////
// Issue cluster top level. Decode, four entries, the issue selector
// and the ALU, with CDB1 fed back from the ALU result register
////////////////////

`timescale 1ns/1ps

module rs_cluster_top (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_valid,
	input  logic [rs_pkg::FUNC_W-1:0] dispatch_func,
	input  logic [rs_pkg::TAG_W-1:0]  dispatch_dest,
	input  logic [rs_pkg::DATA_W-1:0] dispatch_a_value,
	input  logic [rs_pkg::TAG_W-1:0]  dispatch_a_tag,
	input  logic                      dispatch_a_ready,
	input  logic [rs_pkg::DATA_W-1:0] dispatch_b_value,
	input  logic [rs_pkg::TAG_W-1:0]  dispatch_b_tag,
	input  logic                      dispatch_b_ready,
	input  logic                      flush,             // Free every entry
	input  logic                      ext_cdb_valid,     // CDB2
	input  logic [rs_pkg::TAG_W-1:0]  ext_cdb_tag,
	input  logic [rs_pkg::DATA_W-1:0] ext_cdb_value,
	output logic                      rs_full,
	output logic                      result_valid,      // CDB1
	output logic [rs_pkg::TAG_W-1:0]  result_tag,
	output logic [rs_pkg::DATA_W-1:0] result_value
);
	import rs_pkg::*;

	dispatch_if disp ();
	issue_if    iss ();

	entry_state_e          entry_state [RS_ENTRIES];
	alu_op_e               entry_op    [RS_ENTRIES];
	logic [DATA_W-1:0]     entry_a     [RS_ENTRIES];
	logic [DATA_W-1:0]     entry_b     [RS_ENTRIES];
	logic [TAG_W-1:0]      entry_dest  [RS_ENTRIES];
	logic [RS_ENTRIES-1:0] entry_free;
	logic [RS_ENTRIES-1:0] issue_free;

	dispatch_decode decode_i (
		.dispatch_valid   (dispatch_valid),
		.dispatch_func    (dispatch_func),
		.dispatch_dest    (dispatch_dest),
		.dispatch_a_value (dispatch_a_value),
		.dispatch_a_tag   (dispatch_a_tag),
		.dispatch_a_ready (dispatch_a_ready),
		.dispatch_b_value (dispatch_b_value),
		.dispatch_b_tag   (dispatch_b_tag),
		.dispatch_b_ready (dispatch_b_ready),
		.flush            (flush),
		.cdb1_valid       (result_valid),
		.cdb1_tag         (result_tag),
		.cdb1_value       (result_value),
		.cdb2_valid       (ext_cdb_valid),
		.cdb2_tag         (ext_cdb_tag),
		.cdb2_value       (ext_cdb_value),
		.entry_free       (entry_free),
		.rs_full          (rs_full),
		.disp             (disp)
	);

	////////////////////
	// Entry array
	////////////////////
	for (genvar g = 0; g < RS_ENTRIES; g++)
	begin : g_entry
		rs_entry #(.ENTRY_INDEX(g)) entry_i (
			.clock      (clock),
			.reset      (reset),
			.disp       (disp),
			.cdb1_valid (result_valid),
			.cdb1_tag   (result_tag),
			.cdb1_value (result_value),
			.cdb2_valid (ext_cdb_valid),
			.cdb2_tag   (ext_cdb_tag),
			.cdb2_value (ext_cdb_value),
			.flush      (flush),
			.issue_free (issue_free[g]),
			.state      (entry_state[g]),
			.op         (entry_op[g]),
			.a          (entry_a[g]),
			.b          (entry_b[g]),
			.dest       (entry_dest[g])
		);

		assign entry_free[g] = (entry_state[g] == ENTRY_FREE);
	end

	issue_select select_i (
		.clock       (clock),
		.reset       (reset),
		.entry_state (entry_state),
		.entry_op    (entry_op),
		.entry_a     (entry_a),
		.entry_b     (entry_b),
		.entry_dest  (entry_dest),
		.issue_free  (issue_free),
		.iss         (iss)
	);

	alu_execute alu_i (
		.clock        (clock),
		.reset        (reset),
		.iss          (iss),
		.result_valid (result_valid),
		.result_tag   (result_tag),
		.result_value (result_value)
	);

endmodule

/* verilog/rs_entry.sv */
////////////////////
// One reservation station entry. Holds an instruction until both
// operands are present, snooping both CDBs for pending tags.
// Freed on issue or flush
////////////////////

`timescale 1ns/1ps

module rs_entry #(
	parameter int ENTRY_INDEX = 0                        // Bit of disp.load for this slot
) (
	input  logic                      clock,
	input  logic                      reset,
	dispatch_if.entry                 disp,
	input  logic                      cdb1_valid,
	input  logic [rs_pkg::TAG_W-1:0]  cdb1_tag,
	input  logic [rs_pkg::DATA_W-1:0] cdb1_value,
	input  logic                      cdb2_valid,
	input  logic [rs_pkg::TAG_W-1:0]  cdb2_tag,
	input  logic [rs_pkg::DATA_W-1:0] cdb2_value,
	input  logic                      flush,             // Free regardless of state
	input  logic                      issue_free,        // Selected for issue this cycle
	output rs_pkg::entry_state_e      state,
	output rs_pkg::alu_op_e           op,
	output logic [rs_pkg::DATA_W-1:0] a,
	output logic [rs_pkg::DATA_W-1:0] b,
	output logic [rs_pkg::TAG_W-1:0]  dest
);
	import rs_pkg::*;

	logic in_use;
	logic a_ready;
	logic b_ready;
	logic load;
	logic a_hit1, a_hit2;                                // Tag matches per bus
	logic b_hit1, b_hit2;

	assign load   = disp.load[ENTRY_INDEX];

	assign a_hit1 = in_use && !a_ready && cdb1_valid && (cdb1_tag == a[TAG_W-1:0]);
	assign a_hit2 = in_use && !a_ready && cdb2_valid && (cdb2_tag == a[TAG_W-1:0]);
	assign b_hit1 = in_use && !b_ready && cdb1_valid && (cdb1_tag == b[TAG_W-1:0]);
	assign b_hit2 = in_use && !b_ready && cdb2_valid && (cdb2_tag == b[TAG_W-1:0]);

	always_comb
	begin
		if (!in_use)
			state = ENTRY_FREE;
		else if (a_ready && b_ready)
			state = ENTRY_READY;
		else
			state = ENTRY_WAIT;
	end

	////////////////////
	// Occupancy and ready bits
	////////////////////
	always_ff @(posedge clock)
	begin
		if (reset || flush || issue_free)                // Flush beats load
		begin
			in_use  <= 1'b0;
			a_ready <= 1'b0;
			b_ready <= 1'b0;
		end
		else if (load)
		begin
			in_use  <= 1'b1;
			a_ready <= disp.a_ready;
			b_ready <= disp.b_ready;
		end
		else
		begin
			if (a_hit1 || a_hit2)
				a_ready <= 1'b1;
			if (b_hit1 || b_hit2)
				b_ready <= 1'b1;
		end
	end

	////////////////////
	// Instruction fields and operand capture
	////////////////////
	always_ff @(posedge clock)
	begin
		if (load && !flush)
		begin
			op   <= disp.op;
			a    <= disp.a;
			b    <= disp.b;
			dest <= disp.dest;
		end
		else
		begin
			if (a_hit2)                                  // CDB2 wins on double match
				a <= cdb2_value;
			else if (a_hit1)
				a <= cdb1_value;
			if (b_hit2)
				b <= cdb2_value;
			else if (b_hit1)
				b <= cdb1_value;
		end
	end

endmodule

/* verilog/rs_if.sv */
////////////////////
// Bundles between decode, the entries, the selector and the ALU
// dispatch_if carries one-hot entry writes, issue_if carries the
// single-cycle issue strobe
////////////////////

`timescale 1ns/1ps

interface dispatch_if;
	import rs_pkg::*;

	logic [RS_ENTRIES-1:0] load;                        // One-hot entry write
	alu_op_e               op;                          // Decoded opcode
	logic [DATA_W-1:0]     a;                           // Value, or tag when not ready
	logic                  a_ready;
	logic [DATA_W-1:0]     b;                           // Value, or tag when not ready
	logic                  b_ready;
	logic [TAG_W-1:0]      dest;                        // Destination physical tag

	modport decode (output load, op, a, a_ready, b, b_ready, dest);
	modport entry  (input  load, op, a, a_ready, b, b_ready, dest);
endinterface

interface issue_if;
	import rs_pkg::*;

	logic              valid;                           // One pulse per instruction
	alu_op_e           op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [TAG_W-1:0]  dest;

	modport select  (output valid, op, a, b, dest);
	modport execute (input  valid, op, a, b, dest);
endinterface

/* verilog/rs_pkg.sv */
////////////////////
// Shared widths, entry count and enums for the issue cluster
// Modules import this with a wildcard inside the body and use
// scoped names in their port lists
////////////////////

package rs_pkg;

	localparam int DATA_W     = 32;                     // Operand and result width
	localparam int TAG_W      = 5;                      // Physical tag width, 32 tags
	localparam int RS_ENTRIES = 4;                      // Reservation station depth
	localparam int FUNC_W     = 3;                      // Raw function code width
	localparam int IDX_W      = $clog2(RS_ENTRIES);     // Entry index width
	localparam int SHAMT_W    = $clog2(DATA_W);         // Shift amount, low bits of b

	////////////////////
	// ALU opcodes, in function code order
	////////////////////
	typedef enum logic [FUNC_W-1:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7                                  // Signed compare
	} alu_op_e;

	////////////////////
	// Entry occupancy
	////////////////////
	typedef enum logic [1:0] {
		ENTRY_FREE  = 2'd0,                             // Slot available to dispatch
		ENTRY_WAIT  = 2'd1,                             // Holding, operand still pending
		ENTRY_READY = 2'd2                              // Both operands present
	} entry_state_e;

endpackage
